//--- rtl/permConfigPkg.sv
`default_nettype none

package permConfigPkg;

    // Worker layout: 0 serves channel A, 1 serves channel B, 2 is shared
    localparam int PIPELINE_COUNT = 3;
    localparam int CHANNEL_WIDTH = 2; // Own worker plus the shared one
    localparam int SHARED_INDEX = 2;

    // Buffer sizes
    localparam int WORKER_FIFO_DEPTH = 8;
    localparam int ORIGIN_DEPTH = 32;   // Far more than can be in flight
    localparam int OUT_FIFO_DEPTH = 16;

    // Free entries left when almostFull rises, covers registered flags
    localparam int ALMOST_FULL_MARGIN = 4;

    // Input stays closed this long after reset
    localparam int RESET_HOLD_CYCLES = 8;

    // One bit per worker
    typedef logic [PIPELINE_COUNT-1:0] pipeMask;

endpackage

`default_nettype wire

//--- rtl/permDataPkg.sv
`default_nettype none

package permDataPkg;

    // One work item
    typedef logic [127:0] botWord;

    // Upper halves go to A, lower halves to B
    typedef struct packed {
        botWord botA;
        botWord botB;
    } botPair;

    // Count and sum of one bot, 61 bits
    typedef struct packed {
        logic [12:0] pcoeffCount;
        logic [47:0] pcoeffSum;
    } workerResult;

    // Both halves of one accepted input
    typedef struct packed {
        workerResult resultA;
        workerResult resultB;
    } resultPair;

endpackage

`default_nettype wire

//--- rtl/syncFifo.sv
`default_nettype none

module syncFifo #(
    parameter int WIDTH = 8,
    parameter int DEPTH = 16,   // Power of two
    parameter int MARGIN = 4
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             writeEnable,
    input  logic [WIDTH-1:0] dataIn,
    output logic             almostFull,
    output logic             almostEmpty,
    input  logic             readEnable,
    output logic [WIDTH-1:0] dataOut,
    output logic             empty
);

    localparam int ADDR_W = $clog2(DEPTH);
    localparam int COUNT_W = ADDR_W + 1;

    logic [WIDTH-1:0] mem [DEPTH];
    logic [ADDR_W-1:0] wrPtr;
    logic [ADDR_W-1:0] rdPtr;
    logic [COUNT_W-1:0] count;
    logic doWrite;
    logic doRead;

    assign doWrite = writeEnable && (count != COUNT_W'(DEPTH));
    assign doRead = readEnable && !empty;

    assign empty = (count == '0);
    assign almostFull = count >= COUNT_W'(DEPTH - MARGIN);
    assign almostEmpty = count <= COUNT_W'(MARGIN);

    always_ff @(posedge clk) begin
        if (rst) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (doWrite) wrPtr <= wrPtr + 1'b1;
            if (doRead) rdPtr <= rdPtr + 1'b1;
            case ({doWrite, doRead})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (doWrite) mem[wrPtr] <= dataIn;
        if (doRead) dataOut <= mem[rdPtr]; // Valid the cycle after the read
    end

endmodule

`default_nettype wire

//--- rtl/roundRobinSelector.sv
`default_nettype none

module roundRobinSelector
    import permConfigPkg::*;
#(
    parameter int WIDTH = CHANNEL_WIDTH
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             accept,
    input  logic [WIDTH-1:0] almostFulls,
    output logic [WIDTH-1:0] selectedOneHot
);

    logic [WIDTH-1:0] nextOneHot;
    logic [WIDTH-1:0] rotated;

    // Nearest free target wins, otherwise stay put
    always_comb begin
        nextOneHot = selectedOneHot;
        rotated = selectedOneHot;
        for (int i = WIDTH - 1; i >= 1; i--) begin
            rotated = (selectedOneHot << i) | (selectedOneHot >> (WIDTH - i));
            if (|(rotated & ~almostFulls)) nextOneHot = rotated;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) selectedOneHot <= WIDTH'(1);
        else if (accept) selectedOneHot <= nextOneHot;
    end

endmodule

`default_nettype wire

//--- rtl/countWorker.sv
`default_nettype none

module countWorker
    import permConfigPkg::*;
    import permDataPkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  botWord      botIn,
    input  logic        writeBotIn,
    output logic        almostFull,
    output logic        almostEmpty,
    input  logic        readRequest,
    output logic        empty,
    output workerResult dataOut
);

    botWord botData;
    logic inEmpty;
    logic outAlmostFull;
    logic popBot;
    logic busy;
    logic [1:0] phase;   // Which 32-bit word is being added
    logic lastPhase;
    logic [31:0] curWord;
    logic [12:0] accCount;
    logic [47:0] accSum;
    workerResult nextAcc;

    syncFifo #(
        .WIDTH($bits(botWord)),
        .DEPTH(WORKER_FIFO_DEPTH),
        .MARGIN(ALMOST_FULL_MARGIN)
    ) inFifo (
        .clk(clk),
        .rst(rst),
        .writeEnable(writeBotIn),
        .dataIn(botIn),
        .almostFull(almostFull),
        .almostEmpty(almostEmpty),
        .readEnable(popBot),
        .dataOut(botData),
        .empty(inEmpty)
    );

    assign lastPhase = busy && (phase == 2'd3);
    assign popBot = (!busy || lastPhase) && !inEmpty && !outAlmostFull;

    always_comb begin
        curWord = botData[phase*32 +: 32];
        nextAcc.pcoeffCount = (phase == 2'd0 ? 13'd0 : accCount) + 13'($countones(curWord));
        nextAcc.pcoeffSum = (phase == 2'd0 ? 48'd0 : accSum) + 48'(curWord);
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= 1'b0;
            phase <= 2'd0;
        end else begin
            busy <= popBot || (busy && !lastPhase);
            phase <= busy ? phase + 2'd1 : 2'd0; // Wraps back to 0 after word 3
        end
    end

    always_ff @(posedge clk) begin
        accCount <= nextAcc.pcoeffCount;
        accSum <= nextAcc.pcoeffSum;
    end

    syncFifo #(
        .WIDTH($bits(workerResult)),
        .DEPTH(WORKER_FIFO_DEPTH),
        .MARGIN(ALMOST_FULL_MARGIN)
    ) outFifo (
        .clk(clk),
        .rst(rst),
        .writeEnable(lastPhase),
        .dataIn(nextAcc),
        .almostFull(outAlmostFull),
        .almostEmpty(),
        .readEnable(readRequest),
        .dataOut(dataOut),
        .empty(empty)
    );

endmodule

`default_nettype wire

//--- rtl/channelDivider.sv
`default_nettype none

module channelDivider
    import permConfigPkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  logic    accept,
    input  pipeMask almostFulls,
    input  pipeMask almostEmpties,
    output pipeMask selected,
    output logic    sharedSource,
    output logic    almostFull
);

    logic [CHANNEL_WIDTH-1:0] fullsA;
    logic [CHANNEL_WIDTH-1:0] fullsB;
    logic [CHANNEL_WIDTH-1:0] selectedA;
    logic [CHANNEL_WIDTH-1:0] selectedB;
    logic sharedEmptyD;
    logic sharedEmptyDD;
    logic canShareA;
    logic canShareB;
    logic sharedOwner;  // 0 for channel A, 1 for channel B
    logic sharedSelected;
    logic nextOwner;

    always_ff @(posedge clk) begin
        if (rst) begin
            sharedEmptyD <= 1'b0;
            sharedEmptyDD <= 1'b0;
        end else begin
            sharedEmptyD <= almostEmpties[SHARED_INDEX];
            sharedEmptyDD <= sharedEmptyD;
        end
    end

    // Shared worker only helps a channel whose own worker is backed up,
    // unless the shared one is running dry anyway
    assign canShareA = sharedEmptyDD || almostFulls[0];
    assign canShareB = sharedEmptyDD || almostFulls[1];

    assign fullsA = {sharedOwner || !canShareA || almostFulls[SHARED_INDEX], almostFulls[0]};
    assign fullsB = {!sharedOwner || !canShareB || almostFulls[SHARED_INDEX], almostFulls[1]};

    assign sharedSelected = selectedA[CHANNEL_WIDTH-1] || selectedB[CHANNEL_WIDTH-1];

    assign selected[0] = selectedA[0];
    assign selected[1] = selectedB[0];
    assign selected[SHARED_INDEX] = sharedSelected;

    // Tie toggles, else the busier channel gets it
    assign nextOwner = (almostFulls[0] == almostFulls[1]) ? !sharedOwner : almostFulls[1];

    always_ff @(posedge clk) begin
        if (rst) begin
            sharedOwner <= 1'b0;
            sharedSource <= 1'b0;
        end else if (accept) begin
            if (!sharedSelected) sharedOwner <= nextOwner;
            sharedSource <= sharedOwner; // Matches the selection made on this accept
        end
    end

    assign almostFull = &fullsA || &fullsB;

    roundRobinSelector #(.WIDTH(CHANNEL_WIDTH)) selA (
        .clk(clk),
        .rst(rst),
        .accept(accept),
        .almostFulls(fullsA),
        .selectedOneHot(selectedA)
    );

    roundRobinSelector #(.WIDTH(CHANNEL_WIDTH)) selB (
        .clk(clk),
        .rst(rst),
        .accept(accept),
        .almostFulls(fullsB),
        .selectedOneHot(selectedB)
    );

endmodule

`default_nettype wire

//--- rtl/multiPipeline.sv
`default_nettype none

module multiPipeline
    import permConfigPkg::*;
    import permDataPkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      writeBotIn,
    input  botPair    bots,
    output logic      almostFull,
    input  logic      slowDown,
    output logic      resultValid,
    output resultPair resultOut
);

    botWord workerBots [PIPELINE_COUNT];
    workerResult workerData [PIPELINE_COUNT];
    pipeMask workerAlmostFulls;
    pipeMask workerAlmostEmpties;
    pipeMask workerEmpties;
    pipeMask workerWrites;
    pipeMask workerReads;
    pipeMask selected;
    pipeMask headMask;
    pipeMask maskD;
    logic sharedSource;
    logic dividerAlmostFull;
    logic originAlmostFull;
    logic originEmpty;
    logic originRead;
    logic headValid;
    logic headReady;
    logic grabData;
    logic grabD;
    logic grabDD;

    // Shared worker takes whichever half it was assigned
    always_comb begin
        workerBots[0] = bots.botA;
        workerBots[1] = bots.botB;
        workerBots[SHARED_INDEX] = sharedSource ? bots.botB : bots.botA;
    end

    assign workerWrites = writeBotIn ? selected : '0;
    assign almostFull = dividerAlmostFull || originAlmostFull;

    channelDivider divider (
        .clk(clk),
        .rst(rst),
        .accept(writeBotIn),
        .almostFulls(workerAlmostFulls),
        .almostEmpties(workerAlmostEmpties),
        .selected(selected),
        .sharedSource(sharedSource),
        .almostFull(dividerAlmostFull)
    );

    for (genvar i = 0; i < PIPELINE_COUNT; i++) begin : gWorker
        countWorker worker (
            .clk(clk),
            .rst(rst),
            .botIn(workerBots[i]),
            .writeBotIn(workerWrites[i]),
            .almostFull(workerAlmostFulls[i]),
            .almostEmpty(workerAlmostEmpties[i]),
            .readRequest(workerReads[i]),
            .empty(workerEmpties[i]),
            .dataOut(workerData[i])
        );
    end

    // Origin queue records which workers hold each input
    syncFifo #(
        .WIDTH(PIPELINE_COUNT),
        .DEPTH(ORIGIN_DEPTH),
        .MARGIN(ALMOST_FULL_MARGIN)
    ) originQueue (
        .clk(clk),
        .rst(rst),
        .writeEnable(writeBotIn),
        .dataIn(selected),
        .almostFull(originAlmostFull),
        .almostEmpty(),
        .readEnable(originRead),
        .dataOut(headMask),
        .empty(originEmpty)
    );

    // All workers named by the head mask must have a result waiting
    assign headReady = &(~headMask | ~workerEmpties);
    assign grabData = headValid && headReady && !slowDown;
    assign workerReads = grabData ? headMask : '0;
    assign originRead = !originEmpty && (!headValid || grabData);

    always_ff @(posedge clk) begin
        if (rst) begin
            headValid <= 1'b0;
            grabD <= 1'b0;
            grabDD <= 1'b0;
        end else begin
            if (originRead) headValid <= 1'b1;
            else if (grabData) headValid <= 1'b0;
            grabD <= grabData;   // Worker FIFO read
            grabDD <= grabD;     // Output register
        end
    end

    assign resultValid = grabDD;

    always_ff @(posedge clk) begin
        if (grabData) maskD <= headMask;
    end

    always_ff @(posedge clk) begin
        if (grabD) begin
            resultOut.resultA <= maskD[0] ? workerData[0] : workerData[SHARED_INDEX];
            resultOut.resultB <= maskD[1] ? workerData[1] : workerData[SHARED_INDEX];
        end
    end

endmodule

`default_nettype wire

//--- rtl/permutationTop.sv
`default_nettype none

module permutationTop
    import permConfigPkg::*;
    import permDataPkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      ivalid,
    output logic      oready,
    input  botWord    mbfUppers,
    input  botWord    mbfLowers,
    output logic      ovalid,
    input  logic      iready,
    output resultPair results
);

    localparam int HOLD_W = $clog2(RESET_HOLD_CYCLES);

    botPair bots;
    logic [HOLD_W-1:0] holdCount;
    logic holdDone;
    logic pipeAlmostFull;
    logic writeBot;
    logic pipeResultValid;
    resultPair pipeResult;
    logic outFifoAlmostFull;
    logic outFifoAlmostFullD;
    logic outFifoEmpty;
    logic outFifoRead;

    assign bots.botA = {mbfUppers[127:64], mbfLowers[127:64]};
    assign bots.botB = {mbfUppers[63:0], mbfLowers[63:0]};

    // Reset hold counter
    always_ff @(posedge clk) begin
        if (rst) begin
            holdCount <= '0;
            holdDone <= 1'b0;
        end else if (!holdDone) begin
            holdCount <= holdCount + 1'b1;
            if (holdCount == HOLD_W'(RESET_HOLD_CYCLES - 1)) holdDone <= 1'b1;
        end
    end

    assign oready = holdDone && !pipeAlmostFull;
    assign writeBot = ivalid && oready;

    always_ff @(posedge clk) begin
        if (rst) outFifoAlmostFullD <= 1'b0;
        else outFifoAlmostFullD <= outFifoAlmostFull;
    end

    multiPipeline pipes (
        .clk(clk),
        .rst(rst),
        .writeBotIn(writeBot),
        .bots(bots),
        .almostFull(pipeAlmostFull),
        .slowDown(outFifoAlmostFullD),
        .resultValid(pipeResultValid),
        .resultOut(pipeResult)
    );

    // Head slot refills when empty or when the consumer takes it
    assign outFifoRead = !outFifoEmpty && (iready || !ovalid);

    always_ff @(posedge clk) begin
        if (rst) ovalid <= 1'b0;
        else if (outFifoRead) ovalid <= 1'b1;
        else if (iready) ovalid <= 1'b0;
    end

    syncFifo #(
        .WIDTH($bits(resultPair)),
        .DEPTH(OUT_FIFO_DEPTH),
        .MARGIN(ALMOST_FULL_MARGIN)
    ) outFifo (
        .clk(clk),
        .rst(rst),
        .writeEnable(pipeResultValid),
        .dataIn(pipeResult),
        .almostFull(outFifoAlmostFull),
        .almostEmpty(),
        .readEnable(outFifoRead),
        .dataOut(results), // Holds until the next read
        .empty(outFifoEmpty)
    );

endmodule

`default_nettype wire

//--- tb/permTb.sv
`default_nettype none

module permTb
    import permConfigPkg::*;
    import permDataPkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int DRIVE_DELAY = 10;
    // The five tests need under a thousand cycles together
    localparam int TIMEOUT_CYCLES = 6000;

    logic clk;
    logic rst;
    logic ivalid;
    logic oready;
    botWord mbfUppers;
    botWord mbfLowers;
    logic ovalid;
    logic iready;
    resultPair results;

    integer seed = 67050;
    resultPair expected[$];  // Model results in acceptance order
    logic acceptPending;     // Set at negedge, transfer on the next edge
    string currentTest;
    int testCount;
    int checkCount;
    int errorCount;
    int testErrorStart;
    int acceptCount;
    int resultCount;
    int sharedWrites;
    int cycleCount;

    permutationTop u_dut (
        .clk(clk),
        .rst(rst),
        .ivalid(ivalid),
        .oready(oready),
        .mbfUppers(mbfUppers),
        .mbfLowers(mbfLowers),
        .ovalid(ovalid),
        .iready(iready),
        .results(results)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Ones count and sum of the four 32-bit words
    function automatic workerResult botModel(input botWord b);
        workerResult r;
        r.pcoeffCount = '0;
        r.pcoeffSum = '0;
        for (int k = 0; k < 128; k++) begin
            r.pcoeffCount += 13'(b[k]);
        end
        for (int w = 0; w < 4; w++) begin
            r.pcoeffSum += 48'(b[w*32 +: 32]);
        end
        return r;
    endfunction

    function automatic resultPair pairModel(input botWord up, input botWord lo);
        resultPair p;
        p.resultA = botModel({up[127:64], lo[127:64]});
        p.resultB = botModel({up[63:0], lo[63:0]});
        return p;
    endfunction

    function automatic botWord randomBot();
        return {$random(seed), $random(seed), $random(seed), $random(seed)};
    endfunction

    task automatic expectTrue(input bit cond, input string what);
        checkCount++;
        assert (cond) else begin
            $display("%s: %s", currentTest, what);
            errorCount++;
        end
    endtask

    task automatic compareCount(input int want, input int got, input string what);
        checkCount++;
        assert (got == want) else begin
            $display("Mismatch in %s: expected %0d %s, actual %0d",
                     currentTest, want, what, got);
            errorCount++;
        end
    endtask

    task automatic startTest(input string name);
        currentTest = name;
        testErrorStart = errorCount;
        testCount++;
    endtask

    task automatic finishTest();
        $display("%s finished with %0d errors", currentTest, errorCount - testErrorStart);
    endtask

    task automatic presentWord();
        mbfUppers = randomBot();
        mbfLowers = randomBot();
        ivalid = 1'b1;
    endtask

    // Offers count words, data held until accepted
    task automatic streamWords(input int count, input int readyPct);
        int sent;
        sent = 0;
        while (sent < count) begin
            @(posedge clk);
            #DRIVE_DELAY;
            if (ivalid && acceptPending) begin
                sent++;
                ivalid = 1'b0;
            end
            iready = ({$random(seed)} % 100) < readyPct;
            if (sent < count && !ivalid) presentWord();
        end
    endtask

    task automatic holdBack(input int cycles);
        for (int c = 0; c < cycles; c++) begin
            @(posedge clk);
            #DRIVE_DELAY;
            if (ivalid && acceptPending) ivalid = 1'b0;
            iready = 1'b0;
            if (!ivalid) presentWord();
        end
        // Every buffer upstream of the output is stalled by now
        expectTrue(!oready, "oready still high with the output blocked");
        iready = 1'b1;
        while (ivalid) begin  // Last offered word still has to go in
            @(posedge clk);
            #DRIVE_DELAY;
            if (acceptPending) ivalid = 1'b0;
        end
    endtask

    task automatic waitDrain();
        iready = 1'b1;
        while (expected.size() != 0) @(posedge clk);
        repeat (2) @(negedge clk);
        expectTrue(!ovalid, "ovalid still high with no results pending");
        compareCount(acceptCount, resultCount, "results");
    endtask

    // Scoreboard, samples between edges where everything is settled
    always @(negedge clk) begin : monitor
        resultPair want;
        acceptPending = ivalid && oready;
        if (!rst) begin
            if (u_dut.pipes.workerWrites[SHARED_INDEX]) sharedWrites++;
            if (ivalid && oready) begin
                expected.push_back(pairModel(mbfUppers, mbfLowers));
                acceptCount++;
            end
            if (ovalid && iready) begin
                resultCount++;
                expectTrue(expected.size() > 0, "result delivered with no input left to match");
                if (expected.size() > 0) begin
                    want = expected.pop_front();
                    checkCount++;
                    assert (results === want) else begin
                        $display("Mismatch in %s: expected %h, actual %h",
                                 currentTest, want, results);
                        errorCount++;
                    end
                end
            end
        end
    end

    initial begin
        while (cycleCount < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycleCount++;
        end
        $display("Timeout after %0d cycles in %s", cycleCount, currentTest);
        $display("FAIL: see errors above");
        $finish;
    end

    initial begin
        int resultsBefore;
        int sharedBefore;
        rst = 1'b1;
        ivalid = 1'b0;
        iready = 1'b0;
        mbfUppers = '0;
        mbfLowers = '0;

        startTest("resetHold");
        for (int i = 0; i < 3; i++) begin
            @(posedge clk);
            #DRIVE_DELAY;
            expectTrue(!oready && !ovalid, "oready or ovalid high during reset");
        end
        rst = 1'b0;
        for (int i = 0; i < RESET_HOLD_CYCLES; i++) begin
            @(negedge clk);
            expectTrue(!oready && !ovalid, "oready or ovalid high during the reset hold");
        end
        @(negedge clk);
        expectTrue(oready, "oready still low after the reset hold");
        finishTest();

        startTest("singleInput");
        resultsBefore = resultCount;
        streamWords(1, 100);
        waitDrain();
        compareCount(1, resultCount - resultsBefore, "results");
        finishTest();

        startTest("randomStream");
        streamWords(40, 50);
        waitDrain();
        finishTest();

        startTest("sharedBurst");
        sharedBefore = sharedWrites;
        streamWords(60, 100);
        waitDrain();
        expectTrue(sharedWrites > sharedBefore, "burst never reached the shared worker");
        finishTest();

        startTest("backPressure");
        holdBack(200);
        waitDrain();
        finishTest();

        $display("Tests: %0d, checks: %0d, errors: %0d", testCount, checkCount, errorCount);
        if (errorCount == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- project.f
rtl/permConfigPkg.sv
rtl/permDataPkg.sv
rtl/syncFifo.sv
rtl/roundRobinSelector.sv
rtl/countWorker.sv
rtl/channelDivider.sv
rtl/multiPipeline.sv
rtl/permutationTop.sv
tb/permTb.sv

//--- Makefile
TOP = permTb

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing --top-module permutationTop \
		rtl/permConfigPkg.sv rtl/permDataPkg.sv rtl/syncFifo.sv \
		rtl/roundRobinSelector.sv rtl/countWorker.sv rtl/channelDivider.sv \
		rtl/multiPipeline.sv rtl/permutationTop.sv

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) \
		-f project.f -Mdir obj_dir
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q '^PASS: all tests$$'

clean:
	rm -rf obj_dir
